/* cdc_bridge.f */
+incdir+rtl
rtl/cdc_bridge_pkg.sv
rtl/gray_sync.sv
rtl/gray_counter.sv
rtl/dp_ram.sv
rtl/async_fifo.sv
rtl/lane_spreader.sv
rtl/lane_merger.sv
rtl/cdc_bridge_top.sv
bench/cdc_bridge_chk.sv
bench/cdc_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := cdc_bridge_tb
FILELIST  := cdc_bridge.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* bench/cdc_bridge_tb.sv */
`timescale 1ns/1ps

`include "cdc_bridge_defines.svh"

module cdc_bridge_tb
   import cdc_bridge_pkg::*;
();

   localparam int TOTAL_WORDS = `CDC_LANES * (2**`CDC_ADDR_W);
   // tests run about 1200 write cycles, limit leaves 2.5x margin
   localparam int MAX_CYCLES = 3000;

   logic   w_clk;
   logic   r_clk;
   logic   arst_n;
   logic   wr_en;
   data_t  wr_data;
   logic   wr_full;
   level_t wr_level;
   logic   rd_en;
   data_t  rd_data;
   logic   rd_empty;
   level_t rd_level;

   // accepted writes in order
   data_t       model_q [$];
   logic [31:0] lfsr_q;
   int          errors;
   int          cycles;

   cdc_bridge_top dut (
      .w_clk_i    (w_clk),
      .r_clk_i    (r_clk),
      .arst_n_i   (arst_n),
      .wr_en_i    (wr_en),
      .wr_data_i  (wr_data),
      .wr_full_o  (wr_full),
      .wr_level_o (wr_level),
      .rd_en_i    (rd_en),
      .rd_data_o  (rd_data),
      .rd_empty_o (rd_empty),
      .rd_level_o (rd_level)
   );

   initial begin
      w_clk = 1'b0;
      forever begin
         #50 w_clk = ~w_clk;
      end
   end

   initial begin
      r_clk = 1'b0;
      forever begin
         #65 r_clk = ~r_clk;
      end
   end

   // fibonacci lfsr, taps 32 22 2 1, each step shifts one new bit in at bit 0
   function automatic logic [31:0] lfsr_adv(input logic [31:0] state, input int n);
      logic [31:0] s;
      s = state;
      for (int i = 0; i < n; i++) begin
         s = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
      end
      return s;
   endfunction

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic next_w_edge();
      @(posedge w_clk);
      #5;
   endtask

   task automatic next_r_edge();
      @(posedge r_clk);
      #5;
   endtask

   // full is stable through the write cycle, so acceptance is known up front
   task automatic write_word(input logic en, input data_t d);
      logic taken;
      taken   = en && !wr_full;
      wr_en   = en;
      wr_data = d;
      next_w_edge();
      wr_en = 1'b0;
      if (taken) begin
         model_q.push_back(d);
      end
   endtask

   task automatic read_word(input logic en);
      logic  got;
      data_t exp;
      got   = en && !rd_empty;
      rd_en = en;
      next_r_edge();
      rd_en = 1'b0;
      if (got) begin
         if (model_q.size() == 0) begin
            $display("read side delivered a word that was never written");
            abort_run();
         end else begin
            exp = model_q.pop_front();
            check_value("rd_data_o", 32'(rd_data), 32'(exp));
         end
      end
   endtask

   task automatic wait_not_empty();
      int n;
      n = 0;
      while (rd_empty && n < 20) begin
         next_r_edge();
         n++;
      end
      if (rd_empty) begin
         $display("rd_empty_o stayed high for 20 read cycles after a write");
         abort_run();
      end
   endtask

   task automatic reset_values();
      check_value("wr_full_o", 32'(wr_full), 32'd0);
      check_value("rd_empty_o", 32'(rd_empty), 32'd1);
      check_value("wr_level_o", 32'(wr_level), 32'd0);
      check_value("rd_level_o", 32'(rd_level), 32'd0);
   endtask

   task automatic single_words();
      for (int i = 0; i < 8; i++) begin
         lfsr_q = lfsr_adv(lfsr_q, `CDC_DATA_W);
         next_w_edge();
         check_value("wr_full_o", 32'(wr_full), 32'd0);
         write_word(1'b1, data_t'(lfsr_q));
         next_r_edge();
         wait_not_empty();
         read_word(1'b1);
         check_value("rd_empty_o", 32'(rd_empty), 32'd1);
      end
   endtask

   task automatic fill_and_drain();
      next_w_edge();
      for (int i = 0; i < TOTAL_WORDS; i++) begin
         check_value("wr_full_o", 32'(wr_full), 32'd0);
         lfsr_q = lfsr_adv(lfsr_q, `CDC_DATA_W);
         write_word(1'b1, data_t'(lfsr_q));
      end
      check_value("wr_full_o", 32'(wr_full), 32'd1);
      // this one must be dropped
      write_word(1'b1, 16'hdead);
      next_r_edge();
      for (int i = 0; i < TOTAL_WORDS; i++) begin
         wait_not_empty();
         read_word(1'b1);
      end
      repeat (10) next_r_edge();
      check_value("rd_empty_o", 32'(rd_empty), 32'd1);
      check_value("rd_level_o", 32'(rd_level), 32'd0);
   endtask

   task automatic level_tracking();
      int counts [4] = '{1, 6, 17, 32};
      foreach (counts[k]) begin
         next_w_edge();
         for (int i = 0; i < counts[k]; i++) begin
            lfsr_q = lfsr_adv(lfsr_q, `CDC_DATA_W);
            write_word(1'b1, data_t'(lfsr_q));
         end
         repeat (10) next_r_edge();
         check_value("wr_level_o", 32'(wr_level), counts[k]);
         check_value("rd_level_o", 32'(rd_level), counts[k]);
         for (int i = 0; i < counts[k]; i++) begin
            wait_not_empty();
            read_word(1'b1);
         end
         repeat (10) next_r_edge();
         check_value("wr_level_o", 32'(wr_level), 32'd0);
         check_value("rd_level_o", 32'(rd_level), 32'd0);
      end
   endtask

   // writer and reader run in their own clocks with random enables
   task automatic random_traffic();
      logic [31:0] rd_state;
      logic        wr_done;
      rd_state = lfsr_q;
      wr_done  = 1'b0;
      fork
         begin
            next_w_edge();
            for (int i = 0; i < 400; i++) begin
               lfsr_q = lfsr_adv(lfsr_q, 1 + `CDC_DATA_W);
               write_word(lfsr_q[16], data_t'(lfsr_q));
            end
            wr_done = 1'b1;
         end
         begin
            next_r_edge();
            while (!wr_done || model_q.size() != 0) begin
               rd_state = lfsr_adv(rd_state, 1);
               read_word(rd_state[0]);
            end
         end
      join
      repeat (10) next_r_edge();
      check_value("rd_empty_o", 32'(rd_empty), 32'd1);
   endtask

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge w_clk);
         cycles++;
      end
      $display("timeout after %0d write clock cycles", cycles);
      abort_run();
   end

   initial begin
      arst_n  = 1'b0;
      wr_en   = 1'b0;
      wr_data = '0;
      rd_en   = 1'b0;
      errors  = 0;
      lfsr_q  = 32'h2ab1e956;
      repeat (8) @(posedge w_clk);
      #5;
      arst_n = 1'b1;
      reset_values();
      single_words();
      fill_and_drain();
      level_tracking();
      random_traffic();
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         abort_run();
      end
   end

endmodule

/* bench/cdc_bridge_chk.sv */
`timescale 1ns/1ps

`include "cdc_bridge_defines.svh"

module cdc_bridge_chk
   import cdc_bridge_pkg::*;
(
   input logic                  w_clk_i,
   input logic                  r_clk_i,
   input logic                  arst_n_i,
   input logic [`CDC_LANES-1:0] lane_w_taken_i,
   input logic [`CDC_LANES-1:0] lane_w_full_i,
   input logic [`CDC_LANES-1:0] lane_r_taken_i,
   input logic [`CDC_LANES-1:0] lane_r_empty_i,
   input level_t                wr_level_i,
   input level_t                rd_level_i
);

   localparam level_t TOTAL = level_t'(`CDC_LANES * (2**`CDC_ADDR_W));

   // spreader feeds one lane per cycle at most
   a_w_onehot: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      $onehot0(lane_w_taken_i)) else $error("several lane write strobes at once");

   a_w_full: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      (lane_w_taken_i & lane_w_full_i) == '0) else $error("write strobe into a full lane");

   a_r_empty: assert property (@(posedge r_clk_i) disable iff (!arst_n_i)
      (lane_r_taken_i & lane_r_empty_i) == '0) else $error("read strobe from an empty lane");

   // total level bounded by the lane storage on both sides
   a_w_level: assert property (@(posedge w_clk_i) disable iff (!arst_n_i)
      wr_level_i <= TOTAL) else $error("write side level above capacity");

   a_r_level: assert property (@(posedge r_clk_i) disable iff (!arst_n_i)
      rd_level_i <= TOTAL) else $error("read side level above capacity");

endmodule

bind cdc_bridge_top cdc_bridge_chk u_chk (
   .w_clk_i        (w_clk_i),
   .r_clk_i        (r_clk_i),
   .arst_n_i       (arst_n_i),
   .lane_w_taken_i (lane_w_taken),
   .lane_w_full_i  (lane_w_full),
   .lane_r_taken_i (lane_r_taken),
   .lane_r_empty_i (lane_r_empty),
   .wr_level_i     (wr_level_o),
   .rd_level_i     (rd_level_o)
);

/* rtl/cdc_bridge_top.sv */
`timescale 1ns/1ps

`include "cdc_bridge_defines.svh"

module cdc_bridge_top
   import cdc_bridge_pkg::*;
(
   input  logic   w_clk_i,
   input  logic   r_clk_i,
   input  logic   arst_n_i,
   // write side
   input  logic   wr_en_i,
   input  data_t  wr_data_i,
   output logic   wr_full_o,
   output level_t wr_level_o,
   // read side
   input  logic   rd_en_i,
   output data_t  rd_data_o,
   output logic   rd_empty_o,
   output level_t rd_level_o
);

   logic [`CDC_LANES-1:0] lane_w_en;
   logic [`CDC_LANES-1:0] lane_w_taken;
   logic [`CDC_LANES-1:0] lane_w_full;
   ptr_t                  lane_w_level [`CDC_LANES];

   logic [`CDC_LANES-1:0] lane_r_en;
   logic [`CDC_LANES-1:0] lane_r_taken;
   logic [`CDC_LANES-1:0] lane_r_empty;
   ptr_t                  lane_r_level [`CDC_LANES];
   data_t                 lane_r_data [`CDC_LANES];

   lane_spreader u_spreader (
      .w_clk_i        (w_clk_i),
      .arst_n_i       (arst_n_i),
      .wr_en_i        (wr_en_i),
      .wr_full_o      (wr_full_o),
      .wr_level_o     (wr_level_o),
      .lane_w_en_o    (lane_w_en),
      .lane_w_taken_i (lane_w_taken),
      .lane_w_full_i  (lane_w_full),
      .lane_w_level_i (lane_w_level)
   );

   for (genvar g = 0; g < `CDC_LANES; g++) begin : g_lane
      addr_t mem_w_addr;
      addr_t mem_r_addr;

      // flags for the unused direction are left open
      async_fifo u_fifo (
         .w_clk_i      (w_clk_i),
         .r_clk_i      (r_clk_i),
         .arst_n_i     (arst_n_i),
         .w_en_i       (lane_w_en[g]),
         .w_full_o     (lane_w_full[g]),
         .w_empty_o    (),
         .w_level_o    (lane_w_level[g]),
         .r_en_i       (lane_r_en[g]),
         .r_empty_o    (lane_r_empty[g]),
         .r_full_o     (),
         .r_level_o    (lane_r_level[g]),
         .mem_w_en_o   (lane_w_taken[g]),
         .mem_w_addr_o (mem_w_addr),
         .mem_r_en_o   (lane_r_taken[g]),
         .mem_r_addr_o (mem_r_addr)
      );

      dp_ram u_ram (
         .w_clk_i  (w_clk_i),
         .w_en_i   (lane_w_taken[g]),
         .w_addr_i (mem_w_addr),
         .w_data_i (wr_data_i),
         .r_clk_i  (r_clk_i),
         .r_en_i   (lane_r_taken[g]),
         .r_addr_i (mem_r_addr),
         .r_data_o (lane_r_data[g])
      );
   end

   lane_merger u_merger (
      .r_clk_i        (r_clk_i),
      .arst_n_i       (arst_n_i),
      .rd_en_i        (rd_en_i),
      .rd_empty_o     (rd_empty_o),
      .rd_data_o      (rd_data_o),
      .rd_level_o     (rd_level_o),
      .lane_r_en_o    (lane_r_en),
      .lane_r_taken_i (lane_r_taken),
      .lane_r_empty_i (lane_r_empty),
      .lane_r_level_i (lane_r_level),
      .lane_r_data_i  (lane_r_data)
   );

endmodule

/* rtl/lane_merger.sv */
`timescale 1ns/1ps

`include "cdc_bridge_defines.svh"

module lane_merger
   import cdc_bridge_pkg::*;
(
   input  logic                  r_clk_i,
   input  logic                  arst_n_i,
   input  logic                  rd_en_i,
   output logic                  rd_empty_o,
   output data_t                 rd_data_o,
   output level_t                rd_level_o,
   output logic [`CDC_LANES-1:0] lane_r_en_o,
   input  logic [`CDC_LANES-1:0] lane_r_taken_i,
   input  logic [`CDC_LANES-1:0] lane_r_empty_i,
   input  ptr_t                  lane_r_level_i [`CDC_LANES],
   input  data_t                 lane_r_data_i [`CDC_LANES]
);

   localparam lane_t LAST = lane_t'(`CDC_LANES - 1);

   lane_t r_idx_q;
   // lane whose ram output holds the last word read
   lane_t last_q;

   always_comb begin
      lane_r_en_o          = '0;
      lane_r_en_o[r_idx_q] = rd_en_i;
   end

   assign rd_empty_o = lane_r_empty_i[r_idx_q];

   // same visiting order as the spreader keeps words in sequence
   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_idx_q <= '0;
         last_q  <= '0;
      end else if (lane_r_taken_i[r_idx_q]) begin
         r_idx_q <= (r_idx_q == LAST) ? lane_t'(0) : r_idx_q + 1'b1;
         last_q  <= r_idx_q;
      end
   end

   // ram read is registered, so the data shows up one cycle after the strobe
   assign rd_data_o = lane_r_data_i[last_q];

   always_comb begin
      rd_level_o = '0;
      for (int i = 0; i < `CDC_LANES; i++) begin
         rd_level_o = rd_level_o + level_t'(lane_r_level_i[i]);
      end
   end

endmodule

/* rtl/lane_spreader.sv */
`timescale 1ns/1ps

`include "cdc_bridge_defines.svh"

module lane_spreader
   import cdc_bridge_pkg::*;
(
   input  logic                  w_clk_i,
   input  logic                  arst_n_i,
   input  logic                  wr_en_i,
   output logic                  wr_full_o,
   output level_t                wr_level_o,
   output logic [`CDC_LANES-1:0] lane_w_en_o,
   input  logic [`CDC_LANES-1:0] lane_w_taken_i,
   input  logic [`CDC_LANES-1:0] lane_w_full_i,
   input  ptr_t                  lane_w_level_i [`CDC_LANES]
);

   localparam lane_t LAST = lane_t'(`CDC_LANES - 1);

   lane_t w_idx_q;

   // only the selected lane sees the enable
   always_comb begin
      lane_w_en_o          = '0;
      lane_w_en_o[w_idx_q] = wr_en_i;
   end

   assign wr_full_o = lane_w_full_i[w_idx_q];

   // move on once the lane has actually taken the word
   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_idx_q <= '0;
      end else if (lane_w_taken_i[w_idx_q]) begin
         w_idx_q <= (w_idx_q == LAST) ? lane_t'(0) : w_idx_q + 1'b1;
      end
   end

   always_comb begin
      wr_level_o = '0;
      for (int i = 0; i < `CDC_LANES; i++) begin
         wr_level_o = wr_level_o + level_t'(lane_w_level_i[i]);
      end
   end

endmodule

/* rtl/async_fifo.sv */
`timescale 1ns/1ps

`include "cdc_bridge_defines.svh"

module async_fifo
   import cdc_bridge_pkg::*;
(
   input  logic  w_clk_i,
   input  logic  r_clk_i,
   input  logic  arst_n_i,
   // write side
   input  logic  w_en_i,
   output logic  w_full_o,
   output logic  w_empty_o,
   output ptr_t  w_level_o,
   // read side
   input  logic  r_en_i,
   output logic  r_empty_o,
   output logic  r_full_o,
   output ptr_t  r_level_o,
   // memory ports
   output logic  mem_w_en_o,
   output addr_t mem_w_addr_o,
   output logic  mem_r_en_o,
   output addr_t mem_r_addr_o
);

   localparam ptr_t DEPTH = ptr_t'(2**`CDC_ADDR_W);

   function automatic ptr_t gray2bin(input ptr_t gray);
      ptr_t bin;
      bin[`CDC_ADDR_W] = gray[`CDC_ADDR_W];
      for (int i = `CDC_ADDR_W - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // gray pointers, local and synchronized copies
   ptr_t w_wgray;
   ptr_t w_rgray;
   ptr_t r_rgray;
   ptr_t r_wgray;

   // binary pointers in each domain
   ptr_t w_wbin;
   ptr_t w_rbin;
   ptr_t r_rbin;
   ptr_t r_wbin;

   logic w_take;
   logic r_take;

   assign w_wbin = gray2bin(w_wgray);
   assign w_rbin = gray2bin(w_rgray);
   assign r_rbin = gray2bin(r_rgray);
   assign r_wbin = gray2bin(r_wgray);

   // write domain view, read pointer lags so level is pessimistic
   assign w_level_o = w_wbin - w_rbin;
   assign w_full_o  = (w_level_o == DEPTH);
   assign w_empty_o = (w_level_o == '0);

   // read domain view, write pointer lags
   assign r_level_o = r_wbin - r_rbin;
   assign r_full_o  = (r_level_o == DEPTH);
   assign r_empty_o = (r_level_o == '0);

   assign w_take = w_en_i & ~w_full_o;
   assign r_take = r_en_i & ~r_empty_o;

   gray_counter #(.W(`CDC_ADDR_W + 1)) u_w_ptr (
      .clk_i    (w_clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (w_take),
      .gray_o   (w_wgray)
   );

   gray_counter #(.W(`CDC_ADDR_W + 1)) u_r_ptr (
      .clk_i    (r_clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (r_take),
      .gray_o   (r_rgray)
   );

   // write pointer into the read clock
   gray_sync #(.W(`CDC_ADDR_W + 1), .STAGES(`CDC_SYNC_STAGES)) u_w2r_sync (
      .clk_i    (r_clk_i),
      .arst_n_i (arst_n_i),
      .signal_i (w_wgray),
      .signal_o (r_wgray)
   );

   // read pointer into the write clock
   gray_sync #(.W(`CDC_ADDR_W + 1), .STAGES(`CDC_SYNC_STAGES)) u_r2w_sync (
      .clk_i    (w_clk_i),
      .arst_n_i (arst_n_i),
      .signal_i (r_rgray),
      .signal_o (w_rgray)
   );

   assign mem_w_en_o   = w_take;
   assign mem_w_addr_o = w_wbin[`CDC_ADDR_W-1:0];
   assign mem_r_en_o   = r_take;
   assign mem_r_addr_o = r_rbin[`CDC_ADDR_W-1:0];

endmodule

/* rtl/dp_ram.sv */
`timescale 1ns/1ps

`include "cdc_bridge_defines.svh"

module dp_ram
   import cdc_bridge_pkg::*;
(
   input  logic  w_clk_i,
   input  logic  w_en_i,
   input  addr_t w_addr_i,
   input  data_t w_data_i,
   input  logic  r_clk_i,
   input  logic  r_en_i,
   input  addr_t r_addr_i,
   output data_t r_data_o
);

   data_t mem [2**`CDC_ADDR_W];

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read data holds until the next read strobe
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

/* rtl/gray_counter.sv */
`timescale 1ns/1ps

module gray_counter #(
   parameter int W = 4
) (
   input  logic         clk_i,
   input  logic         arst_n_i,
   input  logic         en_i,
   output logic [W-1:0] gray_o
);

   logic [W-1:0] bin_q;
   logic [W-1:0] bin_next;

   assign bin_next = bin_q + 1'b1;

   // gray value is registered so the crossing sees a clean flop output
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bin_q  <= '0;
         gray_o <= '0;
      end else if (en_i) begin
         bin_q  <= bin_next;
         gray_o <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

/* rtl/gray_sync.sv */
`timescale 1ns/1ps

module gray_sync #(
   parameter int W      = 4,
   parameter int STAGES = 2
) (
   input  logic         clk_i,
   input  logic         arst_n_i,
   input  logic [W-1:0] signal_i,
   output logic [W-1:0] signal_o
);

   logic [W-1:0] sync_q [STAGES];

   // only one bit of a gray pointer moves per step, so each stage is safe
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < STAGES; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= signal_i;
         for (int i = 1; i < STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign signal_o = sync_q[STAGES-1];

endmodule

/* rtl/cdc_bridge_pkg.sv */
`include "cdc_bridge_defines.svh"

package cdc_bridge_pkg;

   typedef logic [`CDC_DATA_W-1:0] data_t;
   typedef logic [`CDC_ADDR_W-1:0] addr_t;
   // pointer or lane level, one extra bit for wrap
   typedef logic [`CDC_ADDR_W:0] ptr_t;
   typedef logic [`CDC_LANE_W-1:0] lane_t;
   // total words over all lanes, 0 to 32
   typedef logic [`CDC_ADDR_W+`CDC_LANE_W:0] level_t;

endpackage

/* rtl/cdc_bridge_defines.svh */
`ifndef CDC_BRIDGE_DEFINES_SVH
`define CDC_BRIDGE_DEFINES_SVH

// stream word width
`define CDC_DATA_W 16

// address width inside one lane, 8 words per lane
`define CDC_ADDR_W 3

// number of fifo lanes and width of the lane index
`define CDC_LANES 4
`define CDC_LANE_W 2

// flops in each gray pointer synchronizer
`define CDC_SYNC_STAGES 2

`endif
